// File: Bender.yml
package:
  name: kdi

sources:
  - kdi_pkg.sv
  - kdi_digest_pkg.sv
  - kdi_req_arbiter.sv
  - kdi_digest.sv
  - kdi_key_regs.sv
  - kdi_ctrl_fsm.sv
  - kdi_top.sv
  - target: test
    files:
      - kdi_assertions.sv
      - tb_kdi_top.sv

// File: kdi_assertions.sv
// Handshake and error checks for the key derivation unit
// Bound into the top level, counts every failed property

`timescale 1ns/1ns

module kdi_assertions (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic [kdi_pkg::NumReq-1:0] key_req_i,
  input logic [kdi_pkg::NumReq-1:0] key_ack_i,
  input logic                       edn_req_i,
  input logic                       edn_ack_i,
  input logic                       fsm_err_i
);

  int unsigned fail_cnt = 0;

  // Entropy request held until acked
  a_edn_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_i && !edn_ack_i |=> edn_req_i)
    else begin
      $error("entropy request dropped before its ack");
      fail_cnt++;
    end

  // At most one requester acked at a time
  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(key_ack_i))
    else begin
      $error("more than one key ack");
      fail_cnt++;
    end

  // Ack only for a raised request
  a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (key_ack_i & ~key_req_i) == '0)
    else begin
      $error("key ack without its request");
      fail_cnt++;
    end

  // Error state is terminal
  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_i |=> fsm_err_i)
    else begin
      $error("fsm error dropped");
      fail_cnt++;
    end

endmodule

bind kdi_top kdi_assertions u_assertions (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .key_req_i (key_req_i),
  .key_ack_i (key_ack_o),
  .edn_req_i (edn_req_o),
  .edn_ack_i (edn_ack_i),
  .fsm_err_i (fsm_err_o)
);

// File: kdi_ctrl_fsm.sv
// Key derivation control FSM
// Builds the key in two halves. Each half clears the digest, digests
// two seed blocks, for the SRAM key also two entropy words, and stores
// the finalized result. Nonce words are fetched at the end.
// Escalation or an illegal state ends in a terminal error state.

`timescale 1ns/1ns

module kdi_ctrl_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         kdi_en_i,
  input  logic                         esc_i,
  output logic                         fsm_err_o,
  input  logic                         req_valid_i,
  input  logic                         ingest_entropy_i,
  input  logic                         nonce_two_words_i,
  output logic                         req_done_o,
  output logic                         edn_req_o,
  input  logic                         edn_ack_i,
  output kdi_digest_pkg::digest_cmd_e  cmd_o,
  output logic                         cmd_valid_o,
  input  logic                         cmd_ready_i,
  input  logic                         result_valid_i,
  output logic                         data_sel_o,
  output logic                         key_we_o,
  output logic                         key_half_o,
  output logic                         nonce_we_o,
  output logic                         entropy_idx_o,
  output logic                         seed_valid_we_o,
  output logic [1:0]                   seed_idx_o
);
  import kdi_digest_pkg::*;

  typedef enum logic [3:0] {
    Reset,
    Idle,
    DigClr,
    DigLoad,
    FetchEntropy,
    DigEntropy,
    DigFin,
    DigWait,
    FetchNonce,
    Finish,
    Error
  } state_e;

  state_e     state_d, state_q;
  logic [1:0] seed_cnt_d, seed_cnt_q;
  logic [1:0] entropy_cnt_d, entropy_cnt_q;
  logic       edn_req_d, edn_req_q;
  logic       edn_ack;

  // Only an ack to a pending request counts
  assign edn_ack = edn_ack_i && edn_req_q;

  always_comb begin : p_fsm
    state_d       = state_q;
    seed_cnt_d    = seed_cnt_q;
    entropy_cnt_d = entropy_cnt_q;
    fsm_err_o     = 1'b0;
    req_done_o    = 1'b0;
    // Pending entropy request stays up until acked, even after escalation
    edn_req_d       = edn_req_q && !edn_ack_i;
    cmd_o           = CmdInit;
    cmd_valid_o     = 1'b0;
    data_sel_o      = 1'b0;
    key_we_o        = 1'b0;
    nonce_we_o      = 1'b0;
    seed_valid_we_o = 1'b0;

    case (state_q)
      // Wait for the enable pulse
      Reset: begin
        if (kdi_en_i) begin
          state_d = Idle;
        end
      end
      Idle: begin
        if (req_valid_i) begin
          state_d       = DigClr;
          seed_cnt_d    = '0;
          entropy_cnt_d = '0;
        end
      end
      // Digest back to the initial value of the key type
      DigClr: begin
        cmd_valid_o = 1'b1;
        cmd_o       = CmdInit;
        if (cmd_ready_i) begin
          state_d = DigLoad;
        end
      end
      // Even seed block is loaded, odd one triggers the round
      DigLoad: begin
        cmd_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          cmd_o = CmdDigest;
          if (cmd_ready_i) begin
            state_d = ingest_entropy_i ? FetchEntropy : DigFin;
          end
        end else begin
          cmd_o = CmdLoad;
          if (cmd_ready_i) begin
            seed_cnt_d = seed_cnt_q + 2'd1;
          end
        end
      end
      // Two entropy words for the SRAM key
      FetchEntropy: begin
        edn_req_d = 1'b1;
        if (edn_ack) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == 2'd1) begin
            edn_req_d     = 1'b0;
            entropy_cnt_d = '0;
            state_d       = DigEntropy;
          end else begin
            entropy_cnt_d = entropy_cnt_q + 2'd1;
          end
        end
      end
      DigEntropy: begin
        data_sel_o  = 1'b1;
        cmd_valid_o = 1'b1;
        if (entropy_cnt_q[0]) begin
          cmd_o = CmdDigest;
          if (cmd_ready_i) begin
            entropy_cnt_d = '0;
            state_d       = DigFin;
          end
        end else begin
          cmd_o = CmdLoad;
          if (cmd_ready_i) begin
            entropy_cnt_d = entropy_cnt_q + 2'd1;
          end
        end
      end
      DigFin: begin
        cmd_valid_o = 1'b1;
        cmd_o       = CmdFinalize;
        if (cmd_ready_i) begin
          state_d = DigWait;
        end
      end
      // Store the half, second half moves on to the nonce
      DigWait: begin
        if (result_valid_i) begin
          key_we_o = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            seed_cnt_d = 2'd2;
            state_d    = DigClr;
          end else begin
            seed_cnt_d      = '0;
            seed_valid_we_o = 1'b1;
            state_d         = FetchNonce;
          end
        end
      end
      // One or two nonce words, by requester
      FetchNonce: begin
        edn_req_d = 1'b1;
        if (edn_ack) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == {1'b0, nonce_two_words_i}) begin
            edn_req_d     = 1'b0;
            entropy_cnt_d = '0;
            state_d       = Finish;
          end else begin
            entropy_cnt_d = entropy_cnt_q + 2'd1;
          end
        end
      end
      Finish: begin
        req_done_o = 1'b1;
        state_d    = Idle;
      end
      // Terminal
      Error: begin
        fsm_err_o = 1'b1;
      end
      default: begin
        state_d   = Error;
        fsm_err_o = 1'b1;
      end
    endcase

    if (esc_i) begin
      state_d   = Error;
      fsm_err_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= Reset;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
      edn_req_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      seed_cnt_q    <= seed_cnt_d;
      entropy_cnt_q <= entropy_cnt_d;
      edn_req_q     <= edn_req_d;
    end
  end

  assign edn_req_o     = edn_req_q;
  assign seed_idx_o    = seed_cnt_q;
  assign key_half_o    = seed_cnt_q[1];
  assign entropy_idx_o = entropy_cnt_q[0];

endmodule

// File: kdi_digest.sv
// Arithmetic digest engine
// Init loads the initial value of the key type, load holds one block,
// digest folds the held block and the new block into the state, and
// finalize returns the state mixed with a constant.

`timescale 1ns/1ns

module kdi_digest (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  kdi_pkg::key_sel_e              key_sel_i,
  input  kdi_digest_pkg::digest_cmd_e    cmd_i,
  input  logic                           cmd_valid_i,
  output logic                           cmd_ready_o,
  input  logic [kdi_pkg::BlockWidth-1:0] block_i,
  output logic                           result_valid_o,
  output logic [kdi_pkg::BlockWidth-1:0] result_o
);
  import kdi_pkg::*;
  import kdi_digest_pkg::*;

  localparam int CntWidth = $clog2(DigestLatency + 1);

  logic [BlockWidth-1:0] state_q;
  logic [BlockWidth-1:0] held_q;
  logic [BlockWidth-1:0] mixed;
  logic [CntWidth-1:0]   busy_cnt_q;
  logic                  fin_q;
  logic                  cmd_acc;

  assign cmd_ready_o = (busy_cnt_q == '0);
  assign cmd_acc     = cmd_valid_i && cmd_ready_o;

  // One round: xor, rotate left
  assign mixed = state_q ^ held_q;

  // Digest state and held block
  always_ff @(posedge clk_i) begin : p_data
    if (cmd_acc) begin
      case (cmd_i)
        CmdInit:   state_q <= DigestIv[key_sel_i];
        CmdLoad:   held_q  <= block_i;
        CmdDigest: state_q <= ((mixed << DigestRot) | (mixed >> (BlockWidth - DigestRot)))
                              + block_i;
        default:   ;
      endcase
    end
  end

  // Busy counter, digest and finalize take DigestLatency cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_busy
    if (!rst_ni) begin
      busy_cnt_q <= '0;
      fin_q      <= 1'b0;
    end else if (cmd_acc && (cmd_i == CmdDigest || cmd_i == CmdFinalize)) begin
      busy_cnt_q <= CntWidth'(DigestLatency);
      fin_q      <= (cmd_i == CmdFinalize);
    end else if (busy_cnt_q != '0) begin
      busy_cnt_q <= busy_cnt_q - 1'b1;
    end
  end

  // Result shows in the last busy cycle of a finalize
  assign result_valid_o = fin_q && (busy_cnt_q == CntWidth'(1));
  assign result_o       = state_q ^ DigestFinalConst;

endmodule

// File: kdi_digest_pkg.sv
// Digest engine package
// Command encoding, initial values per key type, finalize constant
// and busy timing of the arithmetic digest

package kdi_digest_pkg;

  // Digest commands
  typedef enum logic [1:0] {
    CmdInit     = 2'd0,
    CmdLoad     = 2'd1,
    CmdDigest   = 2'd2,
    CmdFinalize = 2'd3
  } digest_cmd_e;

  // Initial values, indexed by key type
  // Index 2 SRAM, 1 flash address, 0 flash data
  parameter logic [2:0][63:0] DigestIv = {
    64'h3c1f_9a57_e6d2_0b84,
    64'h7d45_b2e9_1a6c_f038,
    64'h90e3_4f1b_c87a_5d26
  };

  // Mixed into the state on finalize
  parameter logic [63:0] DigestFinalConst = 64'ha5c3_19f7_6e2d_80b4;

  // Left rotate of one digest round
  parameter int DigestRot = 13;

  // Busy cycles of a digest or finalize command
  parameter int DigestLatency = 4;

endpackage

// File: kdi_key_regs.sv
// Key output registers
// Holds the derived key halves, the nonce words and the seed-valid
// flag, and selects the 64-bit block that goes into the digest.

`timescale 1ns/1ns

module kdi_key_regs #(
  parameter logic [kdi_pkg::KeyWidth-1:0]   KeyInit   = '0,
  parameter logic [kdi_pkg::NonceWidth-1:0] NonceInit = '0
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           data_sel_i,
  input  logic                           key_we_i,
  input  logic                           key_half_i,
  input  logic                           nonce_we_i,
  input  logic                           entropy_idx_i,
  input  logic                           seed_valid_we_i,
  input  logic [1:0]                     seed_idx_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  req_seed_i,
  input  logic                           req_seed_valid_i,
  input  logic [kdi_pkg::BlockWidth-1:0] digest_result_i,
  input  logic [kdi_pkg::BlockWidth-1:0] edn_data_i,
  output logic [kdi_pkg::BlockWidth-1:0] block_o,
  output logic [kdi_pkg::KeyWidth-1:0]   key_o,
  output logic [kdi_pkg::NonceWidth-1:0] nonce_o,
  output logic                           seed_valid_o
);
  import kdi_pkg::*;

  logic [1:0][BlockWidth-1:0] key_q;
  logic [1:0][BlockWidth-1:0] nonce_q;
  logic [3:0][BlockWidth-1:0] seed_blocks;
  logic                       seed_valid_q;

  assign seed_blocks = req_seed_i;

  // Key halves, nonce words, seed-valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      key_q        <= KeyInit;
      nonce_q      <= NonceInit;
      seed_valid_q <= 1'b0;
    end else begin
      if (key_we_i) begin
        key_q[key_half_i] <= digest_result_i;
      end
      // Entropy words land in the nonce, also the ones that get digested
      if (nonce_we_i) begin
        nonce_q[entropy_idx_i] <= edn_data_i;
      end
      if (seed_valid_we_i) begin
        seed_valid_q <= req_seed_valid_i;
      end
    end
  end

  // Digest input, seed blocks read as zero when the seed is not valid
  assign block_o = data_sel_i       ? nonce_q[entropy_idx_i] :
                   req_seed_valid_i ? seed_blocks[seed_idx_i] : '0;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

endmodule

// File: kdi_pkg.sv
// Key derivation package
// Widths of seeds, keys, nonces and entropy words, the key type
// encoding and the settings that each requester brings along

package kdi_pkg;

  // One digest block, also one entropy word
  parameter int BlockWidth = 64;
  // Key of two blocks
  parameter int KeyWidth   = 128;
  // Flash seeds hold four blocks, two per key half
  parameter int SeedWidth  = 256;
  // Nonce of two entropy words
  parameter int NonceWidth = 128;
  // Width of the nonce reset value
  parameter int NonceInit_w = NonceWidth;

  // Requesters: 0 flash data, 1 flash address, 2 SRAM
  parameter int NumReq = 3;

  // Key type, picks the digest initial value
  typedef enum logic [1:0] {
    KeyFlashData = 2'd0,
    KeyFlashAddr = 2'd1,
    KeySram      = 2'd2
  } key_sel_e;

  ////////////////////////////////////////////////////
  // Per requester settings, indexed by requester
  ////////////////////////////////////////////////////

  // Key type of each requester
  parameter key_sel_e ReqKeySel [NumReq] = '{KeyFlashData, KeyFlashAddr, KeySram};

  // Only the SRAM key mixes in fresh entropy
  parameter logic [NumReq-1:0] ReqIngestEntropy = 3'b100;

  // Flash address key needs just one nonce word
  parameter logic [NumReq-1:0] ReqNonceTwoWords = 3'b101;

endpackage

// File: kdi_req_arbiter.sv
// Key request arbiter
// Round-robin choice among the three key requesters. The grant is
// registered and held until the control FSM reports the end of the
// derivation, which then becomes the ack of the granted requester.

`timescale 1ns/1ns

module kdi_req_arbiter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [kdi_pkg::NumReq-1:0]     key_req_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_data_seed_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_addr_seed_i,
  input  logic [kdi_pkg::KeyWidth-1:0]   sram_seed_i,
  input  logic                           seed_valid_i,
  input  logic                           req_done_i,
  output logic [kdi_pkg::NumReq-1:0]     key_ack_o,
  output logic                           req_valid_o,
  output kdi_pkg::key_sel_e              key_sel_o,
  output logic                           ingest_entropy_o,
  output logic                           nonce_two_words_o,
  output logic                           seed_valid_o,
  output logic [kdi_pkg::SeedWidth-1:0]  seed_o
);
  import kdi_pkg::*;

  localparam int IdxWidth = $clog2(NumReq);

  logic                busy_q;
  logic [IdxWidth-1:0] idx_q;
  logic [IdxWidth-1:0] ptr_q;
  logic                seed_valid_q;
  logic [IdxWidth-1:0] gnt_idx;
  logic                gnt_found;

  // First requester at or above the pointer, wrapping around
  always_comb begin : p_search
    int j;
    gnt_idx   = '0;
    gnt_found = 1'b0;
    for (int i = 0; i < NumReq; i++) begin
      j = (int'(ptr_q) + i) % NumReq;
      if (!gnt_found && key_req_i[j]) begin
        gnt_idx   = IdxWidth'(j);
        gnt_found = 1'b1;
      end
    end
  end

  // Grant, pointer and seed-valid sample
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_grant
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      idx_q        <= '0;
      ptr_q        <= '0;
      seed_valid_q <= 1'b0;
    end else if (!busy_q) begin
      if (gnt_found) begin
        busy_q       <= 1'b1;
        idx_q        <= gnt_idx;
        ptr_q        <= (gnt_idx == IdxWidth'(NumReq - 1)) ? '0 : gnt_idx + 1'b1;
        seed_valid_q <= seed_valid_i;
      end
    end else if (req_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // Settings of the granted requester
  assign req_valid_o       = busy_q;
  assign key_sel_o         = ReqKeySel[idx_q];
  assign ingest_entropy_o  = ReqIngestEntropy[idx_q];
  assign nonce_two_words_o = ReqNonceTwoWords[idx_q];
  assign seed_valid_o      = seed_valid_q;

  // SRAM seed is used for both key halves
  always_comb begin : p_seed
    case (idx_q)
      IdxWidth'(0): seed_o = flash_data_seed_i;
      IdxWidth'(1): seed_o = flash_addr_seed_i;
      default:      seed_o = {sram_seed_i, sram_seed_i};
    endcase
  end

  // One-cycle ack to the granted index
  assign key_ack_o = (busy_q && req_done_i) ? (NumReq'(1) << idx_q) : '0;

endmodule

// File: kdi_top.f
kdi_pkg.sv
kdi_digest_pkg.sv
kdi_req_arbiter.sv
kdi_digest.sv
kdi_key_regs.sv
kdi_ctrl_fsm.sv
kdi_top.sv
kdi_assertions.sv
tb_kdi_top.sv

// File: kdi_top.sv
// Scrambling key derivation unit
// Three key requesters share one derivation engine through a
// round-robin arbiter. The engine digests seeds and entropy into a
// 128-bit key and fetches a nonce over the entropy port.

`timescale 1ns/1ns

module kdi_top #(
  parameter logic [kdi_pkg::KeyWidth-1:0] KeyInit =
    128'h1f3a_6c90_d2e4_7b58_a0c6_3e19_54f7_8d2b,
  parameter logic [kdi_pkg::NonceInit_w-1:0] NonceInit =
    128'h52d7_0e8c_b61f_49a3_e07c_2b95_d843_16fa
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           kdi_en_i,
  input  logic                           esc_i,
  output logic                           fsm_err_o,
  input  logic                           seed_valid_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_data_seed_i,
  input  logic [kdi_pkg::SeedWidth-1:0]  flash_addr_seed_i,
  input  logic [kdi_pkg::KeyWidth-1:0]   sram_seed_i,
  output logic                           edn_req_o,
  input  logic                           edn_ack_i,
  input  logic [kdi_pkg::BlockWidth-1:0] edn_data_i,
  input  logic [kdi_pkg::NumReq-1:0]     key_req_i,
  output logic [kdi_pkg::NumReq-1:0]     key_ack_o,
  output logic [kdi_pkg::KeyWidth-1:0]   key_o,
  output logic [kdi_pkg::NonceWidth-1:0] nonce_o,
  output logic                           seed_valid_o
);
  import kdi_pkg::*;
  import kdi_digest_pkg::*;

  // Granted request and its settings
  logic                  req_valid;
  key_sel_e              key_sel;
  logic                  ingest_entropy;
  logic                  nonce_two_words;
  logic                  req_seed_valid;
  logic [SeedWidth-1:0]  req_seed;
  logic                  req_done;

  // Digest engine handshake
  digest_cmd_e           cmd;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic                  result_valid;
  logic [BlockWidth-1:0] digest_result;
  logic [BlockWidth-1:0] digest_block;

  // Register file control
  logic                  data_sel;
  logic                  key_we;
  logic                  key_half;
  logic                  nonce_we;
  logic                  entropy_idx;
  logic                  seed_valid_we;
  logic [1:0]            seed_idx;

  //////////////////////////////////////////////////
  // Requester side
  //////////////////////////////////////////////////

  kdi_req_arbiter u_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .key_req_i         (key_req_i),
    .flash_data_seed_i (flash_data_seed_i),
    .flash_addr_seed_i (flash_addr_seed_i),
    .sram_seed_i       (sram_seed_i),
    .seed_valid_i      (seed_valid_i),
    .req_done_i        (req_done),
    .key_ack_o         (key_ack_o),
    .req_valid_o       (req_valid),
    .key_sel_o         (key_sel),
    .ingest_entropy_o  (ingest_entropy),
    .nonce_two_words_o (nonce_two_words),
    .seed_valid_o      (req_seed_valid),
    .seed_o            (req_seed)
  );

  //////////////////////////////////////////////////
  // Derivation engine
  //////////////////////////////////////////////////

  // Sequences both key halves and the nonce fetch
  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .kdi_en_i          (kdi_en_i),
    .esc_i             (esc_i),
    .fsm_err_o         (fsm_err_o),
    .req_valid_i       (req_valid),
    .ingest_entropy_i  (ingest_entropy),
    .nonce_two_words_i (nonce_two_words),
    .req_done_o        (req_done),
    .edn_req_o         (edn_req_o),
    .edn_ack_i         (edn_ack_i),
    .cmd_o             (cmd),
    .cmd_valid_o       (cmd_valid),
    .cmd_ready_i       (cmd_ready),
    .result_valid_i    (result_valid),
    .data_sel_o        (data_sel),
    .key_we_o          (key_we),
    .key_half_o        (key_half),
    .nonce_we_o        (nonce_we),
    .entropy_idx_o     (entropy_idx),
    .seed_valid_we_o   (seed_valid_we),
    .seed_idx_o        (seed_idx)
  );

  // Key, nonce and seed-valid outputs, digest input select
  kdi_key_regs #(
    .KeyInit   (KeyInit),
    .NonceInit (NonceInit)
  ) u_key_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_sel_i       (data_sel),
    .key_we_i         (key_we),
    .key_half_i       (key_half),
    .nonce_we_i       (nonce_we),
    .entropy_idx_i    (entropy_idx),
    .seed_valid_we_i  (seed_valid_we),
    .seed_idx_i       (seed_idx),
    .req_seed_i       (req_seed),
    .req_seed_valid_i (req_seed_valid),
    .digest_result_i  (digest_result),
    .edn_data_i       (edn_data_i),
    .block_o          (digest_block),
    .key_o            (key_o),
    .nonce_o          (nonce_o),
    .seed_valid_o     (seed_valid_o)
  );

  // Initial value follows the granted key type
  kdi_digest u_digest (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .key_sel_i      (key_sel),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .block_i        (digest_block),
    .result_valid_o (result_valid),
    .result_o       (digest_result)
  );

endmodule

// File: tb_kdi_top.sv
// Testbench for the scrambling key derivation unit
// Drives the three key requesters and models the entropy port.
// A reference model rebuilds keys and nonces and checks each ack.

`timescale 1ns/1ns

module tb_kdi_top;
  import kdi_pkg::*;
  import kdi_digest_pkg::*;

  localparam logic [KeyWidth-1:0]   KeyInitVal   = 128'h1f3a_6c90_d2e4_7b58_a0c6_3e19_54f7_8d2b;
  localparam logic [NonceWidth-1:0] NonceInitVal = 128'h6b0e_d341_92fc_a857_3d18_e6a0_c47b_f259;
  localparam int DriveDelay  = 5;
  localparam int AckTimeout  = 1000;
  localparam int QuietCycles = 60;
  // Acks checked over the whole run
  localparam int NumAcks     = 7;

  logic                  clk;
  logic                  rst_n;
  logic                  kdi_en;
  logic                  esc;
  logic                  fsm_err;
  logic                  seed_valid;
  logic [SeedWidth-1:0]  flash_data_seed;
  logic [SeedWidth-1:0]  flash_addr_seed;
  logic [KeyWidth-1:0]   sram_seed;
  logic                  edn_req;
  logic                  edn_ack;
  logic [BlockWidth-1:0] edn_data;
  logic [NumReq-1:0]     key_req;
  logic [NumReq-1:0]     key_ack;
  logic [KeyWidth-1:0]   key_out;
  logic [NonceWidth-1:0] nonce_out;
  logic                  seed_valid_out;

  logic [31:0]           lfsr_q;
  logic [BlockWidth-1:0] entropy_q[$];
  logic [NonceWidth-1:0] exp_nonce;
  int                    rr_ptr;
  int                    acks_checked;

  kdi_top #(
    .KeyInit   (KeyInitVal),
    .NonceInit (NonceInitVal)
  ) u_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .kdi_en_i          (kdi_en),
    .esc_i             (esc),
    .fsm_err_o         (fsm_err),
    .seed_valid_i      (seed_valid),
    .flash_data_seed_i (flash_data_seed),
    .flash_addr_seed_i (flash_addr_seed),
    .sram_seed_i       (sram_seed),
    .edn_req_o         (edn_req),
    .edn_ack_i         (edn_ack),
    .edn_data_i        (edn_data),
    .key_req_i         (key_req),
    .key_ack_o         (key_ack),
    .key_o             (key_out),
    .nonce_o           (nonce_out),
    .seed_valid_o      (seed_valid_out)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("Problem at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic load_seeds();
    logic [63:0] w;
    for (int i = 0; i < 4; i++) begin
      draw_bits(64, w);
      flash_data_seed[64*i +: 64] = w;
      draw_bits(64, w);
      flash_addr_seed[64*i +: 64] = w;
    end
    for (int i = 0; i < 2; i++) begin
      draw_bits(64, w);
      sram_seed[64*i +: 64] = w;
    end
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #DriveDelay;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [63:0] rotl(logic [63:0] x, int r);
    return (x << r) | (x >> (64 - r));
  endfunction

  // Xor the held block, rotate, add the new block
  function automatic logic [63:0] mix_round(logic [63:0] s, logic [63:0] held,
                                            logic [63:0] blk);
    return rotl(s ^ held, DigestRot) + blk;
  endfunction

  function automatic logic [KeyWidth-1:0] ref_key(logic [SeedWidth-1:0] seed, logic valid,
                                                  key_sel_e sel, logic [3:0][63:0] ent);
    logic [KeyWidth-1:0]  k;
    logic [63:0]          s;
    logic [SeedWidth-1:0] used;
    // Invalid seed reads as zero
    used = valid ? seed : '0;
    for (int h = 0; h < 2; h++) begin
      s = DigestIv[sel];
      s = mix_round(s, used[128*h +: 64], used[128*h+64 +: 64]);
      if (sel == KeySram) begin
        s = mix_round(s, ent[2*h], ent[2*h+1]);
      end
      k[64*h +: 64] = s ^ DigestFinalConst;
    end
    return k;
  endfunction

  // Round robin: first request at or above the pointer
  function automatic int expected_grant(logic [NumReq-1:0] req, int ptr);
    int j;
    for (int i = 0; i < NumReq; i++) begin
      j = (ptr + i) % NumReq;
      if (req[j]) begin
        return j;
      end
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Entropy model and checker
  //////////////////////////////////////////////////

  // Acks each word after 0 to 3 cycles
  initial begin : entropy_model
    int          wait_cnt;
    logic        waiting;
    logic [63:0] v;
    waiting = 1'b0;
    wait_cnt = 0;
    forever begin
      next_drive_slot();
      edn_ack = 1'b0;
      if (rst_n && edn_req) begin
        if (!waiting) begin
          draw_bits(2, v);
          wait_cnt = int'(v[1:0]);
          waiting  = 1'b1;
        end
        if (wait_cnt == 0) begin
          draw_bits(64, v);
          edn_ack  = 1'b1;
          edn_data = v;
          entropy_q.push_back(v);
          waiting  = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // Compare outputs in every ack cycle
  initial begin : check_acks
    logic [KeyWidth-1:0]  exp_key;
    logic [SeedWidth-1:0] seed;
    logic [3:0][63:0]     ent;
    key_sel_e             sel;
    int                   idx;
    int                   need;
    exp_nonce    = NonceInitVal;
    rr_ptr       = 0;
    acks_checked = 0;
    forever begin
      @(negedge clk);
      if (key_ack != '0) begin
        idx = expected_grant(key_req, rr_ptr);
        assert (idx >= 0 && key_ack == (NumReq'(1) << idx))
          else report_mismatch($sformatf("ack %b, expected index %0d", key_ack, idx));
        rr_ptr = (idx + 1) % NumReq;
        case (idx)
          0: begin
            sel  = KeyFlashData;
            seed = flash_data_seed;
          end
          1: begin
            sel  = KeyFlashAddr;
            seed = flash_addr_seed;
          end
          default: begin
            sel  = KeySram;
            seed = {sram_seed, sram_seed};
          end
        endcase
        need = (sel == KeySram) ? 6 : (sel == KeyFlashAddr) ? 1 : 2;
        assert (entropy_q.size() == need)
          else report_mismatch($sformatf("%0d entropy words used, expected %0d",
                                         entropy_q.size(), need));
        ent = '0;
        if (sel == KeySram) begin
          for (int i = 0; i < 4; i++) begin
            ent[i] = entropy_q.pop_front();
          end
        end
        // Flash address key refreshes nonce word 0 only
        exp_nonce[63:0] = entropy_q.pop_front();
        if (sel != KeyFlashAddr) begin
          exp_nonce[127:64] = entropy_q.pop_front();
        end
        exp_key = ref_key(seed, seed_valid, sel, ent);
        assert (key_out == exp_key)
          else report_mismatch($sformatf("key %h, expected %h", key_out, exp_key));
        assert (nonce_out == exp_nonce)
          else report_mismatch($sformatf("nonce %h, expected %h", nonce_out, exp_nonce));
        assert (seed_valid_out == seed_valid)
          else report_mismatch($sformatf("seed valid %b, expected %b",
                                         seed_valid_out, seed_valid));
        acks_checked++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Waits until every index in the mask was acked, drops each request after its ack
  task automatic wait_for_acks(input logic [NumReq-1:0] mask);
    logic [NumReq-1:0] pending;
    logic [NumReq-1:0] acked;
    int                cycles;
    pending = mask;
    cycles  = 0;
    while (pending != '0 && cycles < AckTimeout) begin
      @(negedge clk);
      acked = key_ack & pending;
      next_drive_slot();
      key_req = key_req & ~acked;
      pending = pending & ~acked;
      cycles++;
    end
    if (pending != '0) begin
      report_problem($sformatf("no key ack for requests %b", pending));
    end
  endtask

  // No ack may show for a number of cycles
  task automatic expect_no_ack(input int n, input logic err_high);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      assert (key_ack == '0)
        else report_mismatch($sformatf("unexpected key ack %b", key_ack));
      assert (fsm_err == err_high)
        else report_mismatch($sformatf("fsm error %b, expected %b", fsm_err, err_high));
    end
    next_drive_slot();
  endtask

  initial begin : stimulus
    clk             = 1'b0;
    rst_n           = 1'b0;
    kdi_en          = 1'b0;
    esc             = 1'b0;
    seed_valid      = 1'b0;
    edn_ack         = 1'b0;
    edn_data        = '0;
    key_req         = '0;
    flash_data_seed = '0;
    flash_addr_seed = '0;
    sram_seed       = '0;
    lfsr_q          = 32'h67b8_cb9a;
    repeat (10) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;

    // No ack before the enable pulse, reset values on the outputs
    load_seeds();
    seed_valid = 1'b1;
    key_req[0] = 1'b1;
    expect_no_ack(QuietCycles, 1'b0);
    @(negedge clk);
    assert (key_out == KeyInitVal && nonce_out == NonceInitVal && !seed_valid_out)
      else report_mismatch("outputs differ from their reset values");
    next_drive_slot();
    kdi_en = 1'b1;
    next_drive_slot();
    kdi_en = 1'b0;

    // Flash data, flash address, SRAM
    wait_for_acks(3'b001);
    key_req[1] = 1'b1;
    wait_for_acks(3'b010);
    key_req[2] = 1'b1;
    wait_for_acks(3'b100);

    // Invalid seed, then all three requesters at once
    load_seeds();
    seed_valid = 1'b0;
    key_req[0] = 1'b1;
    wait_for_acks(3'b001);
    seed_valid = 1'b1;
    key_req    = 3'b111;
    wait_for_acks(3'b111);

    // Escalation in the middle of a derivation
    key_req[0] = 1'b1;
    repeat (8) next_drive_slot();
    esc = 1'b1;
    next_drive_slot();
    esc = 1'b0;
    expect_no_ack(QuietCycles, 1'b1);

    if (acks_checked == NumAcks && u_dut.u_assertions.fail_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_problem($sformatf("%0d acks checked, %0d assertion failures",
                               acks_checked, u_dut.u_assertions.fail_cnt));
    end
  end

endmodule
